// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - logic/l1_cache_pkg.sv
  - logic/cache_tag_array.sv
  - logic/cache_data_array.sv
  - logic/cache_controller.sv
  - logic/l1_cache.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/mem_model.sv
      - verif/l1_cache_tb.sv

// ==== logic/cache_controller.sv ====
`default_nettype none

module cache_controller (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic store,
    input  logic way_hit,
    input  logic victim_dirty,
    input  logic mem_ready,
    input  logic victim_way,
    input  logic hit_way,
    output logic busy,
    output logic mem_read,
    output logic mem_write,
    output logic mem_addr_sel_victim,
    output logic tag_we,
    output logic store_hit_we,
    output logic fill_dirty,
    output logic data_we,
    output logic data_sel_mem,
    output logic lru_touch,
    output logic fill_way_hold
);
    import l1_cache_pkg::*;

    ctrl_state_t state;
    logic        request;
    logic        idle_free;

    assign request = load | store;

    // idle with busy low is the only place a hit completes toward the processor
    assign idle_free = (state == idle) && !busy;

    assign store_hit_we = idle_free && store && way_hit;
    assign tag_we = (state == write_miss) || ((state == read_miss) && mem_ready);
    assign data_we = tag_we || store_hit_we;
    assign data_sel_mem = (state == read_miss);
    assign fill_dirty = (state == write_miss); // a store allocate leaves the line dirty
    assign lru_touch = tag_we || (idle_free && request && way_hit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            busy <= 1'b0;
            mem_read <= 1'b0;
            mem_write <= 1'b0;
            mem_addr_sel_victim <= 1'b0;
            fill_way_hold <= 1'b0;
        end else begin
            unique case (state)
                idle: begin
                    if (request && !way_hit) begin
                        busy <= 1'b1;
                        fill_way_hold <= victim_way; // the fill must land where the victim was
                        if (victim_dirty) begin
                            mem_write <= 1'b1;
                            mem_addr_sel_victim <= 1'b1;
                            state <= write_back;
                        end else if (load) begin
                            mem_read <= 1'b1;
                            state <= read_miss;
                        end else begin
                            state <= write_miss;
                        end
                    end else begin
                        busy <= 1'b0;
                    end
                end

                write_back: begin
                    if (mem_ready) begin
                        mem_write <= 1'b0;
                        mem_addr_sel_victim <= 1'b0;
                        if (load) begin
                            mem_read <= 1'b1;
                            state <= read_miss;
                        end else begin
                            state <= write_miss;
                        end
                    end
                end

                read_miss: begin
                    if (mem_ready) begin
                        mem_read <= 1'b0; // fill is written on this same edge
                        state <= idle;
                    end
                end

                write_miss: begin
                    state <= idle;
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    a_strobe_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    );

    a_strobe_busy: assert property (
        @(posedge clk) disable iff (!rst_n) (mem_read || mem_write) |-> busy
    );

    // with the request held, the line just filled must hit in the latched way
    a_fill_hits: assert property (
        @(posedge clk) disable iff (!rst_n)
        tag_we |=> (way_hit && (hit_way == fill_way_hold))
    );

endmodule

`default_nettype wire

// ==== logic/cache_data_array.sv ====
`default_nettype none

module cache_data_array (
    input  logic                               clk,
    input  l1_cache_pkg::cache_addr_t          req_addr,
    input  logic                               data_we,
    input  logic                               data_way,
    input  logic                               data_sel_mem,
    input  logic [l1_cache_pkg::data_width-1:0] data_in,
    input  logic [l1_cache_pkg::data_width-1:0] mem_data,
    input  logic                               hit_way,
    input  logic                               victim_way,
    output logic [l1_cache_pkg::data_width-1:0] rd_data,
    output logic [l1_cache_pkg::data_width-1:0] victim_data
);
    import l1_cache_pkg::*;

    logic [data_width-1:0] way_mem [2][num_sets];
    logic [set_width-1:0]  idx;
    logic [data_width-1:0] wr_word;

    assign idx = req_addr.f.index;

    // fills take the fetched word, store hits and store misses take the processor word
    assign wr_word = data_sel_mem ? mem_data : data_in;

    always_ff @(posedge clk) begin
        if (data_we) begin
            way_mem[data_way][idx] <= wr_word;
        end
    end

    assign rd_data = way_mem[hit_way][idx];
    assign victim_data = way_mem[victim_way][idx]; // feeds the write-back

endmodule

`default_nettype wire

// ==== logic/cache_tag_array.sv ====
`default_nettype none

module cache_tag_array (
    input  logic                              clk,
    input  logic                              rst_n,
    input  l1_cache_pkg::cache_addr_t         req_addr,
    input  logic                              tag_we,
    input  logic                              fill_way,
    input  logic                              fill_dirty,
    input  logic                              lru_touch,
    input  logic                              touch_way,
    input  logic                              store_hit_we,
    output logic                              way_hit,
    output logic                              hit_way,
    output logic                              victim_way,
    output logic                              victim_dirty,
    output logic [l1_cache_pkg::tag_width-1:0] victim_tag
);
    import l1_cache_pkg::*;

    logic [num_sets-1:0]  valid_q [2];
    logic [num_sets-1:0]  dirty_q [2];
    logic [num_sets-1:0]  lru_q;        // way to evict next in each set
    logic [tag_width-1:0] tag_mem [2][num_sets];

    logic [set_width-1:0] idx;
    logic [1:0]           match;
    logic                 victim_valid;

    assign idx = req_addr.f.index;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid_q[w][idx] && (tag_mem[w][idx] == req_addr.f.tag);
        end
    end

    assign way_hit = |match;
    assign hit_way = match[1]; // only meaningful while way_hit is high

    // an empty way is always preferred over evicting a live line
    always_comb begin
        if (!valid_q[0][idx]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[idx];
        end
    end

    assign victim_valid = valid_q[victim_way][idx];
    assign victim_dirty = victim_valid && dirty_q[victim_way][idx];
    assign victim_tag = tag_mem[victim_way][idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (tag_we) begin
                valid_q[fill_way][idx] <= 1'b1;
                dirty_q[fill_way][idx] <= fill_dirty;
            end else if (store_hit_we) begin
                dirty_q[hit_way][idx] <= 1'b1;
            end
            if (lru_touch) begin
                lru_q[idx] <= !touch_way; // the other way becomes the older one
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[fill_way][idx] <= req_addr.f.tag;
        end
    end

    // a fill only ever targets a tag that missed in both ways
    a_single_match: assert property (
        @(posedge clk) disable iff (!rst_n) !(match[0] && match[1])
    );

endmodule

`default_nettype wire

// ==== logic/l1_cache.sv ====
`default_nettype none

module l1_cache (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load,
    input  logic                               store,
    input  logic                               mem_ready,
    input  logic [l1_cache_pkg::data_width-1:0] address,
    input  logic [l1_cache_pkg::data_width-1:0] data_in,
    input  logic [l1_cache_pkg::data_width-1:0] mem_data,
    output logic                               hit,
    output logic                               miss,
    output logic                               busy,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic [l1_cache_pkg::data_width-1:0] data_out,
    output logic [l1_cache_pkg::data_width-1:0] mem_addr,
    output logic [l1_cache_pkg::data_width-1:0] mem_write_data
);
    import l1_cache_pkg::*;

    cache_addr_t req_addr;
    cache_addr_t victim_addr;
    cache_addr_t fetch_addr;

    logic way_hit, hit_way, victim_way, victim_dirty;
    logic [tag_width-1:0] victim_tag;
    logic tag_we, store_hit_we, fill_dirty, lru_touch, fill_way_hold;
    logic data_we, data_sel_mem, mem_addr_sel_victim;
    logic touch_way, data_way;
    logic [data_width-1:0] rd_data, victim_data;

    assign req_addr.word = address;

    always_comb begin
        victim_addr.f.tag = victim_tag; // the victim shares the request's set
        victim_addr.f.index = req_addr.f.index;
        victim_addr.f.offset = '0;
        fetch_addr.word = req_addr.word;
        fetch_addr.f.offset = '0;
    end

    assign touch_way = tag_we ? fill_way_hold : hit_way;
    assign data_way = store_hit_we ? hit_way : fill_way_hold;

    cache_tag_array tag_i (
        .clk, .rst_n, .req_addr, .tag_we,
        .fill_way(fill_way_hold), .fill_dirty, .lru_touch, .touch_way, .store_hit_we,
        .way_hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    cache_data_array data_i (
        .clk, .req_addr, .data_we, .data_way, .data_sel_mem, .data_in, .mem_data,
        .hit_way, .victim_way, .rd_data, .victim_data
    );

    cache_controller ctrl_i (
        .clk, .rst_n, .load, .store, .way_hit, .victim_dirty, .mem_ready,
        .victim_way, .hit_way, .busy, .mem_read, .mem_write, .mem_addr_sel_victim,
        .tag_we, .store_hit_we, .fill_dirty, .data_we, .data_sel_mem, .lru_touch,
        .fill_way_hold
    );

    assign hit = way_hit && (load || store);
    assign miss = !way_hit && (load || store);
    assign data_out = rd_data;
    assign mem_addr = mem_addr_sel_victim ? victim_addr.word : fetch_addr.word;
    assign mem_write_data = victim_data;

    // memory must see a steady write-back until it accepts it
    a_wb_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl_i.state == write_back && !mem_ready) |=> ($stable(mem_addr) && $stable(mem_write_data))
    );

endmodule

`default_nettype wire

// ==== logic/l1_cache_pkg.sv ====
`default_nettype none

package l1_cache_pkg;

    localparam int data_width = 32;
    localparam int set_width = 9;
    localparam int tag_width = data_width - set_width - 2;
    localparam int num_sets = 2 ** set_width;

    // a request address seen either as one word or as its lookup fields
    typedef union packed {
        logic [data_width-1:0] word;
        struct packed {
            logic [tag_width-1:0] tag;
            logic [set_width-1:0] index;
            logic [1:0]           offset; // byte offset, always zero toward memory
        } f;
    } cache_addr_t;

    // miss sequencing of the controller
    typedef enum logic [1:0] {
        idle,
        write_back,
        read_miss,
        write_miss
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== project.f ====
logic/l1_cache_pkg.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache_controller.sv
logic/l1_cache.sv
verif/tb_clock_gen.sv
verif/mem_model.sv
verif/l1_cache_tb.sv

// ==== verif/l1_cache_tb.sv ====
`default_nettype none

module l1_cache_tb;
    localparam int clk_period = 40;
    localparam int reset_cycles = 10;
    localparam int random_ops = 2000;
    localparam int directed_ops = 40;
    localparam int worst_cycles = 20; // detect, write-back and fetch at the slowest memory
    localparam longint timeout_time =
        longint'(reset_cycles + (random_ops + directed_ops) * worst_cycles) * clk_period;

    logic        clk;
    logic        rst_n;
    logic        load;
    logic        store;
    logic [31:0] address;
    logic [31:0] data_in;
    logic [31:0] mem_data;
    logic        mem_ready;
    logic        hit;
    logic        miss;
    logic        busy;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] data_out;
    logic [31:0] mem_addr;
    logic [31:0] mem_write_data;

    logic [31:0] shadow [8192];
    logic        shadow_set [8192];
    int          rd_count;
    int          wr_count;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    logic        req_missed;
    string       test_name;

    tb_clock_gen #(.period(clk_period), .reset_cycles(reset_cycles)) clk_i (.clk, .rst_n);

    mem_model mem_i (
        .clk, .rst_n, .mem_read, .mem_write, .mem_addr, .mem_write_data,
        .mem_data, .mem_ready
    );

    l1_cache dut_i (
        .clk, .rst_n, .load, .store, .mem_ready, .address, .data_in, .mem_data,
        .hit, .miss, .busy, .mem_read, .mem_write, .data_out, .mem_addr, .mem_write_data
    );

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // coherent view of memory: the last stored word, else what memory started with
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (shadow_set[addr[14:2]]) begin
            return shadow[addr[14:2]];
        end
        return pattern_word(addr);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set);
        return (32'(tag) << 11) | (32'(set) << 2);
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else report_mismatch(what, exp, act);
    endtask

    // returns at the negedge of the cycle where the request completes
    task automatic access(input logic is_store, input logic [31:0] addr,
                          input logic [31:0] wdata);
        @(posedge clk);
        load <= !is_store;
        store <= is_store;
        address <= addr;
        data_in <= wdata;
        @(negedge clk);
        req_missed = miss; // miss shows in the cycle the request first appears
        while (!(hit && !busy)) begin
            @(negedge clk);
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        load <= 1'b0;
        store <= 1'b0;
    endtask

    // transfers are counted in the cycle before the edge that accepts them
    always @(negedge clk) begin
        if (rst_n && mem_ready && mem_read) begin
            rd_count = rd_count + 1;
            last_rd_addr = mem_addr;
        end
        if (rst_n && mem_ready && mem_write) begin
            wr_count = wr_count + 1;
            last_wr_addr = mem_addr;
            assert (mem_write_data == ref_word(mem_addr))
                else report_mismatch("write-back data", ref_word(mem_addr), mem_write_data);
        end
    end

    always @(negedge clk) begin
        if (rst_n && hit && !busy) begin
            if (load) begin
                assert (data_out == ref_word(address))
                    else report_mismatch("load data", ref_word(address), data_out);
            end else if (store) begin
                shadow[address[14:2]] = data_in; // written by the cache on the next edge
                shadow_set[address[14:2]] = 1'b1;
            end
        end
    end

    initial begin
        #(timeout_time);
        $display("watchdog: requests did not finish within %0d time units", timeout_time);
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [31:0] addr_c;
        int          rd0;
        int          wr0;

        void'($urandom(32'h0f75_bff0));
        load = 1'b0;
        store = 1'b0;
        address = '0;
        data_in = '0;
        rd_count = 0;
        wr_count = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        req_missed = 1'b0;
        test_name = "reset";
        for (int i = 0; i < 8192; i++) begin
            shadow_set[i] = 1'b0;
        end
        @(posedge rst_n);
        @(negedge clk);
        check_eq("busy", 0, busy);
        check_eq("mem_read", 0, mem_read);
        check_eq("mem_write", 0, mem_write);

        test_name = "first_load";
        addr_a = make_addr(3, 17);
        access(1'b0, addr_a, '0);
        check_eq("miss", 1, req_missed);
        check_eq("read count", 1, rd_count);
        check_eq("read address", addr_a, last_rd_addr);
        check_eq("write count", 0, wr_count);
        release_bus();

        test_name = "store_then_load";
        addr_a = make_addr(5, 40);
        rd0 = rd_count;
        wr0 = wr_count;
        access(1'b1, addr_a, 32'hdead_beef);
        access(1'b0, addr_a, '0);
        check_eq("load miss", 0, req_missed);
        check_eq("memory accesses", rd0 + wr0, rd_count + wr_count);
        release_bus();

        test_name = "dirty_eviction";
        addr_a = make_addr(1, 100);
        addr_b = make_addr(2, 100);
        addr_c = make_addr(3, 100);
        access(1'b1, addr_a, 32'h1111_aaaa);
        access(1'b1, addr_b, 32'h2222_bbbb);
        wr0 = wr_count;
        access(1'b0, addr_c, '0);
        check_eq("write count", wr0 + 1, wr_count);
        check_eq("write address", addr_a, last_wr_addr);
        check_eq("memory word", ref_word(addr_a), mem_i.words[addr_a[14:2]]);
        release_bus();

        test_name = "clean_eviction";
        access(1'b0, make_addr(1, 200), '0);
        access(1'b0, make_addr(2, 200), '0);
        rd0 = rd_count;
        wr0 = wr_count;
        access(1'b0, make_addr(3, 200), '0);
        check_eq("write count", wr0, wr_count);
        check_eq("read count", rd0 + 1, rd_count);
        release_bus();

        test_name = "lru_order";
        addr_a = make_addr(1, 300);
        addr_b = make_addr(2, 300);
        access(1'b0, addr_a, '0);
        access(1'b0, addr_b, '0);
        access(1'b0, addr_a, '0); // leaves b as the older way
        access(1'b0, make_addr(3, 300), '0);
        rd0 = rd_count;
        access(1'b0, addr_a, '0);
        check_eq("miss on a", 0, req_missed);
        check_eq("read count after a", rd0, rd_count);
        access(1'b0, addr_b, '0);
        check_eq("miss on b", 1, req_missed);
        check_eq("read count after b", rd0 + 1, rd_count);
        release_bus();

        // 16 tags in each of four neighbouring sets
        test_name = "random_mix";
        for (int i = 0; i < random_ops; i++) begin
            addr_a = make_addr($urandom_range(15, 0), 5 + $urandom_range(3, 0));
            access($urandom_range(1, 0), addr_a, $urandom);
        end
        release_bus();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mem_model.sv ====
`default_nettype none

module mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_write_data,
    output logic [31:0] mem_data,
    output logic        mem_ready
);
    localparam int depth = 8192; // word index is mem_addr[14:2]

    logic [31:0] words [depth];
    logic        pending;
    int unsigned delay;

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    initial begin
        for (int i = 0; i < depth; i++) begin
            words[i] = pattern_word(32'(i) << 2);
        end
        mem_data = '0;
        mem_ready = 1'b0;
        pending = 1'b0;
        delay = 0;
    end

    // ready follows a strobe after one to four cycles and lasts one cycle
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            pending <= 1'b0;
            delay <= 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0; // the cache takes the transfer on this edge
            pending <= 1'b0;
            if (mem_write) begin
                words[mem_addr[14:2]] <= mem_write_data;
            end
        end else if (pending) begin
            if (delay == 0) begin
                mem_ready <= 1'b1;
                mem_data <= words[mem_addr[14:2]];
            end else begin
                delay <= delay - 1;
            end
        end else if (mem_read || mem_write) begin
            pending <= 1'b1;
            delay <= $urandom_range(3, 0);
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int period = 40,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1; // release lands on a rising edge
    end

endmodule

`default_nettype wire
